/* compile.f */
+incdir+verification
verilog/reflector_pkg.sv
verilog/channel_est_apb_regs.sv
verilog/adjust_history.sv
verilog/lane_reflect_filter.sv
verilog/residual_merge.sv
verilog/symbol_adjust_reflector_top.sv
verification/reflector_tb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP      := reflector_tb
FILELIST := compile.f
BUILD    := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

/* verification/reflector_model.svh */
`ifndef REFLECTOR_MODEL_SVH
`define REFLECTOR_MODEL_SVH

typedef struct packed {
    sym_word_t sym;
    adj_word_t adj;
    err_word_t res;
} stream_word_t;

typedef struct packed {
    logic        sel;
    logic        enable;
    logic        write;
    apb_addr_t   addr;
    logic [31:0] wdata;
} apb_req_t;

logic [31:0]  rng_state;
cfg_word_t    cfg_m;
adj_word_t    prev_adj_m;
// [0] history stage, [1] lane stage, [2] output register
stream_word_t word_q[$];
// Injected error of word_q[1] and word_q[2]
err_word_t    inj_q[$];

function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
endfunction

function automatic stream_word_t random_word();
    stream_word_t w;
    for (int k = 0; k < lane_count; k++) begin
        w.sym[k] = sym_t'(next_random());
        w.adj[k] = adj_t'(int'(next_random() % 32'd3) - 1);
        w.res[k] = err_t'(next_random());
    end
    return w;
endfunction

function automatic sym_word_t corrected(sym_word_t sym, adj_word_t adj);
    sym_word_t out;
    sym_t      s;
    adj_t      a;
    int        c;
    for (int k = 0; k < lane_count; k++) begin
        s = sym[k];
        a = adj[k];
        c = int'(s) - 2 * int'(a);
        if (c > sym_max) begin
            c = sym_max;
        end else if (c < -sym_max) begin
            c = -sym_max;
        end
        out[k] = sym_t'(c);
    end
    return out;
endfunction

function automatic err_word_t injected(adj_word_t cur, adj_word_t prev, cfg_word_t cfg);
    adj_t      timeline [2*lane_count];
    err_word_t inj;
    tap_t      tap;
    adj_t      adj;
    int        sum;
    // Previous word first, so lane k of the current word sits at lane_count + k
    for (int k = 0; k < lane_count; k++) begin
        timeline[k]              = prev[k];
        timeline[lane_count + k] = cur[k];
    end
    for (int k = 0; k < lane_count; k++) begin
        sum = 0;
        for (int j = 0; j < tap_count; j++) begin
            tap = cfg[k].taps[j];
            adj = timeline[lane_count + k - j];
            sum += int'(tap) * int'(adj);
        end
        inj[k] = err_t'(sum >>> cfg[k].shift);
    end
    return inj;
endfunction

function automatic logic [31:0] expected_readback(apb_addr_t addr);
    logic [31:0] data;
    lane_cfg_t   lc;
    data = '0;
    if (addr[1:0] == 2'b00) begin
        lc           = cfg_m[addr[3:2]];
        data[7:0]    = lc.taps[0];
        data[15:8]   = lc.taps[1];
        data[23:16]  = lc.taps[2];
        data[26:24]  = lc.shift;
    end
    return data;
endfunction

function automatic void model_reset();
    cfg_m      = '0;
    prev_adj_m = '0;
    word_q.delete();
    inj_q.delete();
    for (int i = 0; i < 3; i++) begin
        word_q.push_back('0);
    end
    for (int i = 0; i < 2; i++) begin
        inj_q.push_back('0);
    end
endfunction

// One clock edge with the given inputs
function automatic void model_step(stream_word_t w, apb_req_t req);
    lane_cfg_t lc;
    inj_q.push_front(injected(word_q[0].adj, prev_adj_m, cfg_m));
    void'(inj_q.pop_back());
    prev_adj_m = word_q[0].adj;
    word_q.push_front(w);
    void'(word_q.pop_back());
    // New taps apply from the next edge on
    if (req.sel && req.enable && req.write && req.addr[1:0] == 2'b00) begin
        lc.taps[0]            = req.wdata[7:0];
        lc.taps[1]            = req.wdata[15:8];
        lc.taps[2]            = req.wdata[23:16];
        lc.shift              = req.wdata[26:24];
        cfg_m[req.addr[3:2]]  = lc;
    end
endfunction

function automatic sym_word_t expected_sym();
    return corrected(word_q[2].sym, word_q[2].adj);
endfunction

function automatic err_word_t expected_res();
    err_word_t r;
    for (int k = 0; k < lane_count; k++) begin
        r[k] = word_q[2].res[k] + inj_q[1][k];
    end
    return r;
endfunction

task automatic compare_sym(string name, sym_word_t expected, sym_word_t actual);
    if (actual !== expected) begin
        $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
        $display("Test failures found");
        $fatal(1, "%s mismatch", name);
    end
endtask

task automatic compare_err(string name, err_word_t expected, err_word_t actual);
    if (actual !== expected) begin
        $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
        $display("Test failures found");
        $fatal(1, "%s mismatch", name);
    end
endtask

task automatic compare_data(string name, logic [31:0] expected, logic [31:0] actual);
    if (actual !== expected) begin
        $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
        $display("Test failures found");
        $fatal(1, "%s mismatch", name);
    end
endtask

`endif

/* verification/reflector_tb.sv */
`timescale 1ns/100ps

module reflector_tb;
    import reflector_pkg::*;

    `include "reflector_model.svh"

    logic         clk;
    logic         rst_i;
    apb_req_t     apb_next;
    apb_req_t     apb_drv;
    stream_word_t word_next;
    stream_word_t word_drv;
    logic [31:0]  prdata;
    sym_word_t    sym_out;
    err_word_t    res_out;
    logic         in_reset;
    logic         random_stream;
    logic         read_pending;
    int           cycle_count = 0;

    symbol_adjust_reflector_top u_dut (
        .clk       (clk),
        .rst_i     (rst_i),
        .psel_i    (apb_drv.sel),
        .penable_i (apb_drv.enable),
        .pwrite_i  (apb_drv.write),
        .paddr_i   (apb_drv.addr),
        .pwdata_i  (apb_drv.wdata),
        .prdata_o  (prdata),
        .sym_i     (word_drv.sym),
        .adj_i     (word_drv.adj),
        .res_err_i (word_drv.res),
        .sym_o     (sym_out),
        .res_err_o (res_out)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= 4000) begin
            $display("Test failures found");
            $fatal(1, "Timeout, the run did not finish within 4000 clock cycles");
        end
    end

    // Check outputs of the last edge before driving the next inputs
    task automatic step_clock();
        @(negedge clk);
        compare_sym("sym_o", expected_sym(), sym_out);
        compare_err("res_err_o", expected_res(), res_out);
        if (read_pending) begin
            compare_data("prdata_o", expected_readback(apb_drv.addr), prdata);
            read_pending = 1'b0;
        end
        if (random_stream) begin
            word_next = random_word();
        end
        rst_i    = in_reset;
        apb_drv  = apb_next;
        word_drv = word_next;
        if (in_reset) begin
            model_reset();
        end else begin
            model_step(word_drv, apb_drv);
        end
    endtask

    task automatic apb_write(apb_addr_t addr, logic [31:0] data);
        apb_next = '{sel: 1'b1, enable: 1'b0, write: 1'b1, addr: addr, wdata: data};
        step_clock();
        apb_next.enable = 1'b1;
        step_clock();
        apb_next = '0;
    endtask

    // Readback is checked at the start of the following cycle
    task automatic apb_read(apb_addr_t addr);
        apb_next = '{sel: 1'b1, enable: 1'b0, write: 1'b0, addr: addr, wdata: '0};
        step_clock();
        apb_next.enable = 1'b1;
        step_clock();
        read_pending = 1'b1;
        apb_next     = '0;
    endtask

    task automatic write_all_lanes(logic [31:0] data);
        for (int n = 0; n < lane_count; n++) begin
            apb_write(apb_addr_t'(4 * n), data);
        end
    endtask

    // Single flips in the edge lanes followed by quiet words that let them ring out
    task automatic isolated_flips();
        int lanes [2] = '{0, 3};
        for (int i = 0; i < 2; i++) begin
            for (int p = -1; p <= 1; p += 2) begin
                word_next                = '0;
                word_next.adj[lanes[i]]  = adj_t'(p);
                step_clock();
                word_next = '0;
                repeat (4) step_clock();
            end
        end
    endtask

    initial begin
        clk           = 1'b0;
        rst_i         = 1'b1;
        in_reset      = 1'b1;
        random_stream = 1'b0;
        read_pending  = 1'b0;
        rng_state     = 32'h9c16;
        apb_next      = '0;
        apb_drv       = '0;
        word_next     = '0;
        word_drv      = '0;
        model_reset();

        // Traffic during reset must leave no trace
        random_stream = 1'b1;
        for (int i = 0; i < 16; i++) begin
            apb_next = '{sel: 1'b1, enable: 1'b1, write: 1'b1,
                         addr: apb_addr_t'(4 * (i % lane_count)), wdata: next_random()};
            step_clock();
        end
        apb_next      = '0;
        random_stream = 1'b0;
        word_next     = '0;
        in_reset      = 1'b0;
        for (int n = 0; n < lane_count; n++) begin
            apb_read(apb_addr_t'(4 * n));
        end

        // Correction only with all taps zero
        random_stream = 1'b1;
        repeat (200) step_clock();
        random_stream = 1'b0;
        word_next     = '0;

        for (int n = 0; n < lane_count; n++) begin
            apb_write(apb_addr_t'(4 * n), next_random());
        end
        for (int n = 0; n < lane_count; n++) begin
            apb_read(apb_addr_t'(4 * n));
        end
        // Unaligned slots are not registers
        apb_write(4'd14, 32'hffff_ffff);
        apb_read(4'd12);
        apb_read(4'd13);
        apb_read(4'd14);
        apb_read(4'd15);
        apb_read(4'd6);

        write_all_lanes(32'h0000_0025);
        isolated_flips();
        write_all_lanes(32'h0200_b000);
        isolated_flips();
        write_all_lanes(32'h0141_0000);
        isolated_flips();
        write_all_lanes(32'h03a5_5a7f);
        isolated_flips();

        random_stream = 1'b1;
        for (int i = 0; i < 1500; i++) begin
            if (i % 100 == 50) begin
                apb_write(apb_addr_t'(4 * (next_random() % 32'd4)), next_random());
            end else begin
                step_clock();
            end
        end
        random_stream = 1'b0;
        word_next     = '0;
        repeat (4) step_clock();

        $display("All tests passed!");
        $finish;
    end

endmodule : reflector_tb

/* verilog/symbol_adjust_reflector_top.sv */
`timescale 1ns/100ps

module symbol_adjust_reflector_top (
    input  logic                     clk,
    input  logic                     rst_i,

    input  logic                     psel_i,
    input  logic                     penable_i,
    input  logic                     pwrite_i,
    input  reflector_pkg::apb_addr_t paddr_i,
    input  logic [31:0]              pwdata_i,
    output logic [31:0]              prdata_o,

    input  reflector_pkg::sym_word_t sym_i,
    input  reflector_pkg::adj_word_t adj_i,
    input  reflector_pkg::err_word_t res_err_i,

    output reflector_pkg::sym_word_t sym_o,
    output reflector_pkg::err_word_t res_err_o
);
    import reflector_pkg::*;

    cfg_word_t                        cfg;
    sym_word_t                        hist_sym;
    adj_word_t                        hist_adj;
    err_word_t                        hist_res_err;
    adj_window_t [lane_count-1:0]     hist_windows;
    sym_word_t                        lane_sym;
    err_word_t                        lane_inj_err;

    channel_est_apb_regs u_regs (
        .clk       (clk),
        .rst_i     (rst_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .cfg_o     (cfg)
    );

    adjust_history u_history (
        .clk       (clk),
        .rst_i     (rst_i),
        .sym_i     (sym_i),
        .adj_i     (adj_i),
        .res_err_i (res_err_i),
        .sym_o     (hist_sym),
        .adj_o     (hist_adj),
        .res_err_o (hist_res_err),
        .windows_o (hist_windows)
    );

    for (genvar k = 0; k < lane_count; k++) begin : g_lane
        lane_reflect_filter u_filter (
            .clk       (clk),
            .rst_i     (rst_i),
            .sym_i     (hist_sym[k]),
            .adj_i     (hist_adj[k]),
            .window_i  (hist_windows[k]),
            .cfg_i     (cfg[k]),
            .sym_o     (lane_sym[k]),
            .inj_err_o (lane_inj_err[k])
        );
    end

    residual_merge u_merge (
        .clk       (clk),
        .rst_i     (rst_i),
        .res_err_i (hist_res_err),
        .sym_i     (lane_sym),
        .inj_err_i (lane_inj_err),
        .sym_o     (sym_o),
        .res_err_o (res_err_o)
    );

endmodule : symbol_adjust_reflector_top

/* verilog/residual_merge.sv */
`timescale 1ns/100ps

module residual_merge (
    input  logic                     clk,
    input  logic                     rst_i,

    input  reflector_pkg::err_word_t res_err_i,
    input  reflector_pkg::sym_word_t sym_i,
    input  reflector_pkg::err_word_t inj_err_i,

    output reflector_pkg::sym_word_t sym_o,
    output reflector_pkg::err_word_t res_err_o
);
    import reflector_pkg::*;

    err_word_t res_dly_q;
    err_word_t err_sum;
    sym_word_t sym_q;
    err_word_t res_err_q;

    // Match the lane filter register
    always_ff @(posedge clk) begin
        if (rst_i) begin
            res_dly_q <= '0;
        end else begin
            res_dly_q <= res_err_i;
        end
    end

    // Wraps at 8 bits
    always_comb begin
        for (int k = 0; k < lane_count; k++) begin
            err_sum[k] = res_dly_q[k] + inj_err_i[k];
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            sym_q     <= '0;
            res_err_q <= '0;
        end else begin
            sym_q     <= sym_i;
            res_err_q <= err_sum;
        end
    end

    assign sym_o     = sym_q;
    assign res_err_o = res_err_q;

endmodule : residual_merge

/* verilog/lane_reflect_filter.sv */
`timescale 1ns/100ps

module lane_reflect_filter (
    input  logic                       clk,
    input  logic                       rst_i,

    input  reflector_pkg::sym_t        sym_i,
    input  reflector_pkg::adj_t        adj_i,
    input  reflector_pkg::adj_window_t window_i,
    input  reflector_pkg::lane_cfg_t   cfg_i,

    output reflector_pkg::sym_t        sym_o,
    output reflector_pkg::err_t        inj_err_o
);
    import reflector_pkg::*;

    logic signed [sym_width+1:0] sym_ext;
    logic signed [sym_width+1:0] adj_ext;
    logic signed [sym_width+1:0] corr_wide;
    sym_t                        corr_sym;
    acc_t                        acc;
    acc_t                        acc_shifted;
    sym_t                        sym_q;
    err_t                        inj_q;

    // Flip the symbol, then clamp to the symbol range
    always_comb begin
        sym_ext   = sym_i;
        adj_ext   = adj_i;
        corr_wide = sym_ext - (adj_ext <<< 1);
        if (corr_wide > sym_max) begin
            corr_sym = sym_t'(sym_max);
        end else if (corr_wide < -sym_max) begin
            corr_sym = sym_t'(-sym_max);
        end else begin
            corr_sym = sym_t'(corr_wide);
        end
    end

    // Error injected through the channel estimate
    always_comb begin
        acc = '0;
        for (int j = 0; j < tap_count; j++) begin
            acc = acc + acc_t'(cfg_i.taps[j]) * acc_t'(window_i[j]);
        end
        acc_shifted = acc >>> cfg_i.shift;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            sym_q <= '0;
            inj_q <= '0;
        end else begin
            sym_q <= corr_sym;
            inj_q <= err_t'(acc_shifted);
        end
    end

    assign sym_o     = sym_q;
    assign inj_err_o = inj_q;

    no_neg_full_scale: assert property (
        @(posedge clk) disable iff (rst_i)
        sym_q != sym_t'(-sym_max - 1)
    ) else $error("corrected symbol reached -4");

endmodule : lane_reflect_filter

/* verilog/adjust_history.sv */
`timescale 1ns/100ps

module adjust_history (
    input  logic                     clk,
    input  logic                     rst_i,

    input  reflector_pkg::sym_word_t sym_i,
    input  reflector_pkg::adj_word_t adj_i,
    input  reflector_pkg::err_word_t res_err_i,

    output reflector_pkg::sym_word_t sym_o,
    output reflector_pkg::adj_word_t adj_o,
    output reflector_pkg::err_word_t res_err_o,
    output reflector_pkg::adj_window_t [reflector_pkg::lane_count-1:0] windows_o
);
    import reflector_pkg::*;

    sym_word_t                 sym_q;
    adj_word_t                 adj_q;
    adj_word_t                 adj_prev_q;
    err_word_t                 res_err_q;
    adj_t [2*lane_count-1:0]   stream;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            sym_q      <= '0;
            adj_q      <= '0;
            adj_prev_q <= '0;
            res_err_q  <= '0;
        end else begin
            sym_q      <= sym_i;
            adj_q      <= adj_i;
            adj_prev_q <= adj_q;
            res_err_q  <= res_err_i;
        end
    end

    // Time-ordered: previous word in 0..3, current word in 4..7
    assign stream = {adj_q, adj_prev_q};

    always_comb begin
        for (int k = 0; k < lane_count; k++) begin
            for (int j = 0; j < tap_count; j++) begin
                windows_o[k][j] = stream[lane_count + k - j];
            end
        end
    end

    assign sym_o     = sym_q;
    assign adj_o     = adj_q;
    assign res_err_o = res_err_q;

    // Detector only issues flips of one step
    for (genvar k = 0; k < lane_count; k++) begin : g_adj_chk
        adj_in_range: assert property (
            @(posedge clk) disable iff (rst_i)
            (adj_q[k] >= -1) && (adj_q[k] <= 1)
        ) else $error("adjustment out of range on lane %0d", k);
    end

endmodule : adjust_history

/* verilog/channel_est_apb_regs.sv */
`timescale 1ns/100ps

module channel_est_apb_regs (
    input  logic                     clk,
    input  logic                     rst_i,

    input  logic                     psel_i,
    input  logic                     penable_i,
    input  logic                     pwrite_i,
    input  reflector_pkg::apb_addr_t paddr_i,
    input  logic [31:0]              pwdata_i,
    output logic [31:0]              prdata_o,

    output reflector_pkg::cfg_word_t cfg_o
);
    import reflector_pkg::*;

    cfg_word_t             cfg_q;
    logic [addr_width-3:0] slot;
    logic                  slot_hit;
    logic                  wr_en;
    logic                  rd_en;

    // Word-aligned lane slots only
    assign slot     = paddr_i[addr_width-1:2];
    assign slot_hit = (paddr_i[1:0] == 2'b00) && (int'(slot) < lane_count);

    // Access phase write, no wait states
    assign wr_en = psel_i && penable_i && pwrite_i && slot_hit;
    assign rd_en = psel_i && !pwrite_i && slot_hit;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            cfg_q <= '0;
        end else if (wr_en) begin
            cfg_q[slot] <= pwdata_i[$bits(lane_cfg_t)-1:0];
        end
    end

    // Readback, unused bits stay zero
    always_comb begin
        prdata_o = '0;
        if (rd_en) begin
            prdata_o[$bits(lane_cfg_t)-1:0] = cfg_q[slot];
        end
    end

    assign cfg_o = cfg_q;

    // Access phase must follow a setup phase with psel held
    penable_needs_psel: assert property (
        @(posedge clk) disable iff (rst_i)
        $rose(penable_i) |-> psel_i
    ) else $error("penable rose without psel");

endmodule : channel_est_apb_regs

/* verilog/reflector_pkg.sv */
package reflector_pkg;

    localparam int lane_count  = 4;
    localparam int tap_count   = 3;
    localparam int sym_max     = 3;

    localparam int sym_width   = 3;
    localparam int adj_width   = 3;
    localparam int err_width   = 8;
    localparam int tap_width   = 8;
    localparam int shift_width = 3;
    localparam int acc_width   = 13;
    localparam int addr_width  = 4;

    typedef logic signed [sym_width-1:0]   sym_t;
    // Only -1, 0 and +1 carry meaning
    typedef logic signed [adj_width-1:0]   adj_t;
    typedef logic signed [err_width-1:0]   err_t;
    typedef logic signed [tap_width-1:0]   tap_t;
    typedef logic        [shift_width-1:0] shift_t;
    typedef logic signed [acc_width-1:0]   acc_t;

    // Byte address, lane n at 4*n
    typedef logic [addr_width-1:0] apb_addr_t;

    // Lane 0 is the oldest symbol of the word
    typedef sym_t [lane_count-1:0] sym_word_t;
    typedef adj_t [lane_count-1:0] adj_word_t;
    typedef err_t [lane_count-1:0] err_word_t;

    // Layout matches the APB data word: taps in bytes 0..2, shift in 26:24
    typedef struct packed {
        shift_t               shift;
        tap_t [tap_count-1:0] taps;
    } lane_cfg_t;

    typedef lane_cfg_t [lane_count-1:0] cfg_word_t;

    // Entry j is the adjustment j symbols before the lane's own
    typedef adj_t [tap_count-1:0] adj_window_t;

endpackage : reflector_pkg
